//--- files.f
+incdir+dv
source/reflector_pkg.sv
source/bit_history_window.sv
source/lane_error_injector.sv
source/residual_error_combiner.sv
source/flip_bit_reflector.sv
dv/flip_bit_reflector_tb.sv

//--- dv/reflector_model.svh
`ifndef REFLECTOR_MODEL_SVH
`define REFLECTOR_MODEL_SVH

// Frame seen on the last accepted strobe
logic [reflector_pkg::lane_count-1:0] model_prev_sliced = '0;
logic [reflector_pkg::lane_count-1:0] model_prev_flip = '0;

// Clamp events seen by the model
int sat_high_hits = 0;
int sat_low_hits = 0;

logic [31:0] lcg_state = 32'h836c1c54;

function automatic logic [31:0] rand32();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

function automatic void model_reset();
    model_prev_sliced = '0;
    model_prev_flip = '0;
endfunction

// Signed residual range, -512 to +511
function automatic reflector_pkg::err_t clamp_residual(input int value);
    int hi;
    int lo;
    int v;
    hi = (1 << (reflector_pkg::err_width - 1)) - 1;
    lo = -(1 << (reflector_pkg::err_width - 1));
    v = value;
    if (v > hi) begin
        sat_high_hits++;
        v = hi;
    end else if (v < lo) begin
        sat_low_hits++;
        v = lo;
    end
    return v[reflector_pkg::err_width-1:0];
endfunction

// Expected output for one accepted frame, advances the history
function automatic reflector_pkg::out_frame_t model_frame(
    input reflector_pkg::in_frame_t                 f,
    input reflector_pkg::tap_set_t                  taps,
    input logic [reflector_pkg::shift_width-1:0]    shift
);
    reflector_pkg::out_frame_t result;
    reflector_pkg::coef_t coef;
    reflector_pkg::err_t res;
    reflector_pkg::err_t inj;
    int pos;
    int acc;
    int tap;
    int sum;
    logic s_bit;
    logic f_bit;
    logic [31:0] acc_bits;
    result.bits = f.sliced ^ f.flip;
    for (int i = 0; i < reflector_pkg::lane_count; i++) begin
        acc = 0;
        for (int k = 0; k < reflector_pkg::tap_count; k++) begin
            pos = i - k;
            if (pos >= 0) begin
                s_bit = f.sliced[pos];
                f_bit = f.flip[pos];
            end else begin
                s_bit = model_prev_sliced[reflector_pkg::lane_count + pos];
                f_bit = model_prev_flip[reflector_pkg::lane_count + pos];
            end
            coef = taps[k];
            tap = coef;
            // A flipped 1 adds twice the tap, a flipped 0 removes it
            if (f_bit && s_bit) begin
                acc = acc + 2 * tap;
            end else if (f_bit) begin
                acc = acc - 2 * tap;
            end
        end
        acc = acc >>> shift;
        acc_bits = acc;
        inj = acc_bits[reflector_pkg::err_width-1:0];
        res = f.res_err[i];
        sum = res;
        sum = sum + inj;
        result.res_err[i] = clamp_residual(sum);
    end
    model_prev_sliced = f.sliced;
    model_prev_flip = f.flip;
    return result;
endfunction

`endif

//--- dv/flip_bit_reflector_tb.sv
`timescale 1ns/1ns
`default_nettype none

module flip_bit_reflector_tb;

    // Strobes plus gap cycles over all tests
    localparam int planned_cycles = 1 + 100 + 200 + 400 + 60;
    localparam int cycle_limit = 2 * planned_cycles + 16 + 20;

    logic                                   clk;
    logic                                   rst_i;
    logic                                   valid_i;
    reflector_pkg::in_frame_t               frame_i;
    reflector_pkg::tap_set_t                taps_i;
    logic [reflector_pkg::shift_width-1:0]  shift_i;
    logic                                   valid_o;
    reflector_pkg::out_frame_t              frame_o;

    int cycle_count = 0;
    int errors = 0;
    int frames_checked = 0;
    int tests_run = 0;

    // Expected frames and the cycle each one is due
    reflector_pkg::out_frame_t  exp_q[$];
    int                         due_q[$];
    reflector_pkg::out_frame_t  exp_frame;

    `include "reflector_model.svh"

    flip_bit_reflector dut0 (
        .clk     (clk),
        .rst_i   (rst_i),
        .valid_i (valid_i),
        .frame_i (frame_i),
        .taps_i  (taps_i),
        .shift_i (shift_i),
        .valid_o (valid_o),
        .frame_o (frame_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
        end
        $display("Run stopped: cycle limit of %0d reached before the tests finished", cycle_limit);
        $display("TEST FAILED");
        $finish;
    end

    task automatic report_mismatch(input reflector_pkg::out_frame_t want);
        if (frame_o.bits !== want.bits) begin
            $display("ERR frame_o.bits exp %h got %h at cycle %0d",
                     want.bits, frame_o.bits, cycle_count);
            errors++;
        end
        for (int i = 0; i < reflector_pkg::lane_count; i++) begin
            if (frame_o.res_err[i] !== want.res_err[i]) begin
                $display("ERR frame_o.res_err[%0d] exp %h got %h at cycle %0d",
                         i, want.res_err[i], frame_o.res_err[i], cycle_count);
                errors++;
            end
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (due_q.size() != 0 && due_q[0] == cycle_count) begin
            exp_frame = exp_q.pop_front();
            void'(due_q.pop_front());
            if (valid_o !== 1'b1) begin
                $display("Missing output: valid_o low at cycle %0d where a frame was due",
                         cycle_count);
                errors++;
            end else if (frame_o !== exp_frame) begin
                report_mismatch(exp_frame);
            end else begin
                frames_checked++;
            end
        end else if (valid_o !== 1'b0) begin
            $display("Unexpected output: valid_o high at cycle %0d with no frame due",
                     cycle_count);
            errors++;
        end
    end

    function automatic reflector_pkg::in_frame_t random_frame(input logic with_flips);
        reflector_pkg::in_frame_t f;
        logic [31:0] r;
        r = rand32();
        f.sliced = r[31 -: reflector_pkg::lane_count];
        f.flip = with_flips ? r[15 -: reflector_pkg::lane_count] : '0;
        for (int i = 0; i < reflector_pkg::lane_count; i++) begin
            r = rand32();
            f.res_err[i] = r[31 -: reflector_pkg::err_width];
        end
        return f;
    endfunction

    function automatic reflector_pkg::tap_set_t random_taps();
        reflector_pkg::tap_set_t t;
        logic [31:0] r;
        for (int k = 0; k < reflector_pkg::tap_count; k++) begin
            r = rand32();
            t[k] = r[31 -: reflector_pkg::coef_width];
        end
        return t;
    endfunction

    // Taps of 48 to 63 in magnitude keep the injection inside 10 bits
    function automatic reflector_pkg::tap_set_t saturation_taps(input logic neg_taps);
        reflector_pkg::tap_set_t t;
        logic [31:0] r;
        int v;
        for (int k = 0; k < reflector_pkg::tap_count; k++) begin
            r = rand32();
            v = 48 + int'(r[31:28]);
            if (neg_taps) begin
                v = -v;
            end
            t[k] = v[reflector_pkg::coef_width-1:0];
        end
        return t;
    endfunction

    function automatic reflector_pkg::in_frame_t saturation_frame(input logic neg_taps);
        reflector_pkg::in_frame_t f;
        logic [31:0] r;
        logic up;
        int v;
        r = rand32();
        up = r[31];
        f.flip = '1;
        f.sliced = up ? '1 : '0;
        for (int i = 0; i < reflector_pkg::lane_count; i++) begin
            r = rand32();
            // Residual leans the same way as the injection
            if (up != neg_taps) begin
                v = 480 + int'(r[31:27]);
            end else begin
                v = -512 + int'(r[31:27]);
            end
            f.res_err[i] = v[reflector_pkg::err_width-1:0];
        end
        return f;
    endfunction

    // Valid low, junk on the data lines
    task automatic idle_cycle();
        @(negedge clk);
        valid_i = 1'b0;
        frame_i = random_frame(1'b1);
    endtask

    task automatic send_frame(input reflector_pkg::in_frame_t f);
        @(negedge clk);
        valid_i = 1'b1;
        frame_i = f;
        exp_q.push_back(model_frame(f, taps_i, shift_i));
        due_q.push_back(cycle_count + 3);
    endtask

    task automatic drain();
        while (due_q.size() != 0) begin
            idle_cycle();
        end
        repeat (2) idle_cycle();
    endtask

    // Only called with nothing in flight
    task automatic set_config(input reflector_pkg::tap_set_t taps,
                              input logic [reflector_pkg::shift_width-1:0] shift);
        taps_i = taps;
        shift_i = shift;
    endtask

    task automatic report_test(input string name, input int err_start, input int frames);
        tests_run++;
        $display("%-16s %0d frames, %0d errors", name, frames, errors - err_start);
    endtask

    initial begin
        int err_start;
        logic [31:0] r;
        rst_i = 1'b1;
        valid_i = 1'b0;
        frame_i = '0;
        taps_i = '0;
        shift_i = '0;
        model_reset();
        repeat (16) @(negedge clk);
        rst_i = 1'b0;

        // First frame sees an all-zero history
        err_start = errors;
        if (frame_o !== reflector_pkg::out_frame_t'(0)) begin
            $display("ERR frame_o after reset exp %h got %h",
                     reflector_pkg::out_frame_t'(0), frame_o);
            errors++;
        end
        repeat (5) idle_cycle();
        r = rand32();
        set_config(random_taps(), r[31 -: reflector_pkg::shift_width]);
        send_frame(random_frame(1'b1));
        drain();
        report_test("reset_state", err_start, 1);

        err_start = errors;
        for (int b = 0; b < 4; b++) begin
            r = rand32();
            set_config(random_taps(), r[31 -: reflector_pkg::shift_width]);
            repeat (25) send_frame(random_frame(1'b0));
            drain();
        end
        report_test("no_flips", err_start, 100);

        err_start = errors;
        r = rand32();
        set_config(random_taps(), r[31 -: reflector_pkg::shift_width]);
        repeat (200) send_frame(random_frame(1'b1));
        drain();
        report_test("back_to_back", err_start, 200);

        err_start = errors;
        r = rand32();
        set_config(random_taps(), r[31 -: reflector_pkg::shift_width]);
        for (int n = 0; n < 100; n++) begin
            send_frame(random_frame(1'b1));
            r = rand32();
            repeat (r[31:30]) idle_cycle();
        end
        drain();
        report_test("gapped_strobes", err_start, 100);

        err_start = errors;
        sat_high_hits = 0;
        sat_low_hits = 0;
        for (int p = 0; p < 2; p++) begin
            set_config(saturation_taps(p[0]), '0);
            repeat (30) send_frame(saturation_frame(p[0]));
            drain();
        end
        if (sat_high_hits == 0 || sat_low_hits == 0) begin
            $display("Saturation stimulus did not reach both limits: %0d high, %0d low",
                     sat_high_hits, sat_low_hits);
            errors++;
        end
        report_test("saturation", err_start, 60);

        $display("Summary: %0d tests, %0d frames checked, %0d errors",
                 tests_run, frames_checked, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/flip_bit_reflector.sv
`timescale 1ns/1ns
`default_nettype none

module flip_bit_reflector (
    input  logic                                    clk,
    input  logic                                    rst_i,
    input  logic                                    valid_i,
    input  reflector_pkg::in_frame_t                frame_i,
    input  reflector_pkg::tap_set_t                 taps_i,
    input  logic [reflector_pkg::shift_width-1:0]   shift_i,
    output logic                                    valid_o,
    output reflector_pkg::out_frame_t               frame_o
);

    // Registered per-lane windows
    reflector_pkg::lane_taps_t [reflector_pkg::lane_count-1:0] win;
    logic                                                      win_valid;

    // Injected error of every lane
    reflector_pkg::err_t [reflector_pkg::lane_count-1:0]       inj_err;

    bit_history_window window0 (
        .clk         (clk),
        .rst_i       (rst_i),
        .valid_i     (valid_i),
        .sliced_i    (frame_i.sliced),
        .flip_i      (frame_i.flip),
        .win_o       (win),
        .win_valid_o (win_valid)
    );

    // One injector per lane, all sharing the tap set
    generate
        for (genvar gi = 0; gi < reflector_pkg::lane_count; gi++) begin : lanes
            lane_error_injector injector0 (
                .clk       (clk),
                .rst_i     (rst_i),
                .win_i     (win[gi]),
                .taps_i    (taps_i),
                .shift_i   (shift_i),
                .inj_err_o (inj_err[gi])
            );
        end
    endgenerate

    residual_error_combiner combiner0 (
        .clk         (clk),
        .rst_i       (rst_i),
        .valid_i     (valid_i),
        .frame_i     (frame_i),
        .win_valid_i (win_valid),
        .inj_err_i   (inj_err),
        .valid_o     (valid_o),
        .frame_o     (frame_o)
    );

endmodule

`default_nettype wire

//--- source/residual_error_combiner.sv
`timescale 1ns/1ns
`default_nettype none

module residual_error_combiner (
    input  logic                                                    clk,
    input  logic                                                    rst_i,
    input  logic                                                    valid_i,
    input  reflector_pkg::in_frame_t                                frame_i,
    input  logic                                                    win_valid_i,
    input  reflector_pkg::err_t [reflector_pkg::lane_count-1:0]     inj_err_i,
    output logic                                                    valid_o,
    output reflector_pkg::out_frame_t                               frame_o
);

    // Delay line for residuals and corrected bits
    logic [reflector_pkg::lane_count-1:0]                 corr_q1;
    logic [reflector_pkg::lane_count-1:0]                 corr_q2;
    reflector_pkg::err_t [reflector_pkg::lane_count-1:0]  res_q1;
    reflector_pkg::err_t [reflector_pkg::lane_count-1:0]  res_q2;
    logic                                                 valid_q2;

    // One extra bit so the sum cannot wrap
    logic signed [reflector_pkg::err_width:0]             sum;
    reflector_pkg::err_t [reflector_pkg::lane_count-1:0]  res_sat;

    // Stage 1, same edge as the window register
    always_ff @(posedge clk) begin
        if (valid_i) begin
            corr_q1 <= frame_i.sliced ^ frame_i.flip;
            res_q1  <= frame_i.res_err;
        end
    end

    // Stage 2, same edge as the injector register
    always_ff @(posedge clk) begin
        if (win_valid_i) begin
            corr_q2 <= corr_q1;
            res_q2  <= res_q1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q2 <= 1'b0;
        end else begin
            valid_q2 <= win_valid_i;
        end
    end

    // Add and clamp per lane
    always_comb begin
        sum = '0;
        for (int i = 0; i < reflector_pkg::lane_count; i++) begin
            sum = res_q2[i] + inj_err_i[i];
            // Top two bits differ on overflow
            if (sum[reflector_pkg::err_width] != sum[reflector_pkg::err_width-1]) begin
                res_sat[i] = sum[reflector_pkg::err_width] ? reflector_pkg::err_min
                                                           : reflector_pkg::err_max;
            end else begin
                res_sat[i] = sum[reflector_pkg::err_width-1:0];
            end
        end
    end

    // Output register
    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o <= 1'b0;
            frame_o <= '0;
        end else begin
            valid_o <= valid_q2;
            if (valid_q2) begin
                frame_o.bits    <= corr_q2;
                frame_o.res_err <= res_sat;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/lane_error_injector.sv
`timescale 1ns/1ns
`default_nettype none

module lane_error_injector (
    input  logic                                    clk,
    input  logic                                    rst_i,
    input  reflector_pkg::lane_taps_t               win_i,
    input  reflector_pkg::tap_set_t                 taps_i,
    input  logic [reflector_pkg::shift_width-1:0]   shift_i,
    output reflector_pkg::err_t                     inj_err_o
);

    logic signed [reflector_pkg::acc_width-1:0] tap_ext;
    logic signed [reflector_pkg::acc_width-1:0] term;
    logic signed [reflector_pkg::acc_width-1:0] acc;
    logic signed [reflector_pkg::acc_width-1:0] acc_shifted;

    // Sum of the error change each proposed flip injects
    always_comb begin
        acc     = '0;
        tap_ext = '0;
        term    = '0;
        for (int k = 0; k < reflector_pkg::tap_count; k++) begin
            // Sign extend the tap before doubling
            tap_ext = taps_i[k];
            if (!win_i.flip[k]) begin
                term = '0;
            end else if (win_i.sliced[k]) begin
                term = tap_ext <<< 1;
            end else begin
                term = -(tap_ext <<< 1);
            end
            acc = acc + term;
        end
    end

    // Channel scaling, arithmetic shift keeps the sign
    assign acc_shifted = acc >>> shift_i;

    // Truncated to the residual width
    always_ff @(posedge clk) begin
        if (rst_i) begin
            inj_err_o <= '0;
        end else begin
            inj_err_o <= acc_shifted[reflector_pkg::err_width-1:0];
        end
    end

endmodule

`default_nettype wire

//--- source/bit_history_window.sv
`timescale 1ns/1ns
`default_nettype none

module bit_history_window (
    input  logic                                    clk,
    input  logic                                    rst_i,
    input  logic                                    valid_i,
    input  logic [reflector_pkg::lane_count-1:0]    sliced_i,
    input  logic [reflector_pkg::lane_count-1:0]    flip_i,
    output reflector_pkg::lane_taps_t [reflector_pkg::lane_count-1:0] win_o,
    output logic                                    win_valid_o
);

    // Previous frame as seen on the last strobe
    logic [reflector_pkg::lane_count-1:0] prev_sliced;
    logic [reflector_pkg::lane_count-1:0] prev_flip;

    // Current frame on top of the previous one, lane 0 of now sits at index lane_count
    logic [2*reflector_pkg::lane_count-1:0] ext_sliced;
    logic [2*reflector_pkg::lane_count-1:0] ext_flip;

    reflector_pkg::lane_taps_t [reflector_pkg::lane_count-1:0] win_d;

    assign ext_sliced = {sliced_i, prev_sliced};
    assign ext_flip   = {flip_i, prev_flip};

    // Tap-aligned window per lane
    always_comb begin
        for (int i = 0; i < reflector_pkg::lane_count; i++) begin
            for (int k = 0; k < reflector_pkg::tap_count; k++) begin
                // Negative positions fall into the previous frame
                win_d[i].sliced[k] = ext_sliced[reflector_pkg::lane_count + i - k];
                win_d[i].flip[k]   = ext_flip[reflector_pkg::lane_count + i - k];
            end
        end
    end

    // History and window valid
    always_ff @(posedge clk) begin
        if (rst_i) begin
            prev_sliced <= '0;
            prev_flip   <= '0;
            win_valid_o <= 1'b0;
        end else begin
            win_valid_o <= valid_i;
            // Only a strobe moves the history forward
            if (valid_i) begin
                prev_sliced <= sliced_i;
                prev_flip   <= flip_i;
            end
        end
    end

    // Window stage, loads every cycle
    always_ff @(posedge clk) begin
        win_o <= win_d;
    end

endmodule

`default_nettype wire

//--- source/reflector_pkg.sv
`default_nettype none

package reflector_pkg;

    // Frame geometry
    localparam int lane_count = 8;
    localparam int tap_count = 4;

    // Word widths
    localparam int err_width = 10;
    localparam int coef_width = 8;
    localparam int shift_width = 3;
    // Holds tap_count terms of twice the largest tap
    localparam int acc_width = 14;

    typedef logic signed [err_width-1:0] err_t;
    typedef logic signed [coef_width-1:0] coef_t;

    // Clamp limits of a residual, -512 and +511
    localparam err_t err_max = {1'b0, {(err_width - 1){1'b1}}};
    localparam err_t err_min = {1'b1, {(err_width - 1){1'b0}}};

    // Channel estimate, tap 0 is the cursor
    typedef coef_t [tap_count-1:0] tap_set_t;

    typedef struct packed {
        logic [lane_count-1:0] sliced;
        logic [lane_count-1:0] flip;
        err_t [lane_count-1:0] res_err;
    } in_frame_t;

    typedef struct packed {
        logic [lane_count-1:0] bits;
        err_t [lane_count-1:0] res_err;
    } out_frame_t;

    // Index k looks k symbols before the lane
    typedef struct packed {
        logic [tap_count-1:0] sliced;
        logic [tap_count-1:0] flip;
    } lane_taps_t;

endpackage

`default_nettype wire
